// File: hw/cpuBusPkg.sv
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Z80-style bus constants and memory map
// RAM is 1 KB and only decoded in block 0
// IO port number travels on address bits 15..8
// Reads that hit no device return 8'hFF
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package cpuBusPkg;

    // Bus widths
    localparam int addrWidth = 16;
    localparam int dataWidth = 8;

    // 1 KB of RAM in the lowest 1 KB block
    localparam int ramAddrWidth = 10;
    localparam logic [addrWidth-ramAddrWidth-1:0] ramBlock = '0;

    // IO ports of the UART
    localparam logic [7:0] uartDataPort = 8'h00;
    localparam logic [7:0] uartStatusPort = 8'h01;

    // Value seen on reads nobody answers
    localparam logic [dataWidth-1:0] openBusValue = 8'hFF;

    // Pacing counter width, one tick per 2**cpuSlowdown clocks
    localparam int cpuSlowdown = 4;

    // Memory view: 1 KB block and offset inside it
    typedef struct packed {
        logic [addrWidth-ramAddrWidth-1:0] block;
        logic [ramAddrWidth-1:0] offset;
    } memAddrT;

    // IO view: port on the high byte, as the Z80 drives it for IN/OUT (n)
    typedef struct packed {
        logic [addrWidth-dataWidth-1:0] port;
        logic [dataWidth-1:0] low;
    } ioAddrT;

    // Same 16 address bits, decoded per cycle type
    typedef union packed {
        memAddrT mem;
        ioAddrT io;
    } cpuAddrU;

endpackage
`default_nettype wire

// File: hw/uartPkg.sv
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART frame and bit timing
// Bit time is counted in clk cycles, no baud divider
// Frame is 8N1, LSB first
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package uartPkg;

    // clk cycles per bit on the line
    localparam int clocksPerBit = 8;

    // Payload bits per frame
    localparam int dataBits = 8;

    // Start bit, data bits, stop bit
    localparam int frameBits = 10;

endpackage
`default_nettype wire

// File: hw/cpuBusIf.sv
`timescale 1ns/1ps
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decoded CPU bus between decoder and peripherals
// Strobes are active high and last one clk for writes
// Read strobes hold while the CPU holds its pins
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
interface cpuBusIf;

    // Registered address and write data
    cpuBusPkg::cpuAddrU addr;
    logic [cpuBusPkg::dataWidth-1:0] wrData;

    // Cycle strobes
    logic ramWe;
    logic ramRe;
    logic ioWr;
    logic ioRd;

    // Read data returned by the peripherals
    logic [cpuBusPkg::dataWidth-1:0] ramRdData;
    logic [cpuBusPkg::dataWidth-1:0] uartRdData;

    modport decoder (
        output addr, wrData, ramWe, ramRe, ioWr, ioRd,
        input  ramRdData, uartRdData
    );

    modport ram (
        input  addr, wrData, ramWe, ramRe,
        output ramRdData
    );

    modport uart (
        input  addr, wrData, ioWr, ioRd,
        output uartRdData
    );

endinterface
`default_nettype wire

// File: hw/cpuTiming.sv
`timescale 1ns/1ps
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU pacing tick and debounced CPU reset
// cpuTick is an enable, not a clock
// cpuReset asserts with rst, releases on a tick
// Release can lag rst by up to 17 clk cycles
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module cpuTiming (
    input  logic clk,
    input  logic rst,
    output logic cpuTick,
    output logic cpuReset
);

    // Free-running pacing counter
    logic [cpuBusPkg::cpuSlowdown-1:0] paceCnt;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pacing
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            paceCnt <= '0;
            cpuTick <= 1'b0;
        end else begin
            paceCnt <= paceCnt + 1'b1;
            // One pulse per wrap of the counter
            cpuTick <= &paceCnt;
        end
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reset resample
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Push-button bounce shorter than a tick never reaches the CPU side
    always_ff @(posedge clk) begin
        if (rst) begin
            cpuReset <= 1'b1;
        end else if (cpuTick) begin
            cpuReset <= 1'b0;
        end
    end

    // Tick is a single-cycle enable, never a level
    tickSingle: assert property (
        @(posedge clk) disable iff (rst) cpuTick |=> !cpuTick
    );

endmodule
`default_nettype wire

// File: hw/busDecoder.sv
`timescale 1ns/1ps
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Active-low Z80 bus to decoded strobes
// Pins are sampled once per clk, no synchronizer
// Write strobes fire once per nWr low phase
// Read data is valid 2 clk after the pins are seen
// No wait states, refresh or interrupt cycles
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module busDecoder (
    input  logic clk,
    input  logic rst,
    input  cpuBusPkg::cpuAddrU addr,
    input  logic [cpuBusPkg::dataWidth-1:0] wrData,
    input  logic nMreq,
    input  logic nIorq,
    input  logic nRd,
    input  logic nWr,
    output logic [cpuBusPkg::dataWidth-1:0] rdData,
    cpuBusIf.decoder bus
);

    // Cycle type, only one request pin low is a valid cycle
    logic memCycle;
    logic ioCycle;
    logic ramHit;

    // Write condition and its previous sample
    logic wrCond;
    logic wrCondQ;
    logic wrEdge;

    // Read source, aligned with the peripheral read data
    logic ramSelQ;
    logic uartSelQ;

    assign memCycle = !nMreq && nIorq;
    assign ioCycle = !nIorq && nMreq;
    assign ramHit = (addr.mem.block == cpuBusPkg::ramBlock);

    assign wrCond = !nWr && (!nMreq || !nIorq);
    // First sample of the write condition
    assign wrEdge = wrCond && !wrCondQ;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pin capture and strobes
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        bus.addr <= addr;
        bus.wrData <= wrData;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrCondQ <= 1'b0;
            bus.ramWe <= 1'b0;
            bus.ramRe <= 1'b0;
            bus.ioWr <= 1'b0;
            bus.ioRd <= 1'b0;
        end else begin
            wrCondQ <= wrCond;
            // Writes outside block 0 are dropped here
            bus.ramWe <= wrEdge && memCycle && ramHit;
            bus.ioWr <= wrEdge && ioCycle;
            // Reads follow the pins
            bus.ramRe <= !nRd && memCycle && ramHit;
            bus.ioRd <= !nRd && ioCycle;
        end
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read data mux
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            ramSelQ <= 1'b0;
            uartSelQ <= 1'b0;
            rdData <= cpuBusPkg::openBusValue;
        end else begin
            ramSelQ <= bus.ramRe;
            // Only the status port answers a read
            uartSelQ <= bus.ioRd && (bus.addr.io.port == cpuBusPkg::uartStatusPort);
            if (ramSelQ) begin
                rdData <= bus.ramRdData;
            end else if (uartSelQ) begin
                rdData <= bus.uartRdData;
            end else begin
                rdData <= cpuBusPkg::openBusValue;
            end
        end
    end

    // A glitch with both request pins low must not hit RAM and IO at once
    wrExclusive: assert property (
        @(posedge clk) disable iff (rst) !(bus.ramWe && bus.ioWr)
    );

endmodule
`default_nettype wire

// File: hw/hostRam.sv
`timescale 1ns/1ps
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 1 KB single-port RAM on the decoded bus
// One clk of read latency
// Contents are undefined after power-up
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module hostRam (
    input logic clk,
    cpuBusIf.ram bus
);

    // Storage, indexed by the memory view offset
    logic [cpuBusPkg::dataWidth-1:0] mem [0:(1 << cpuBusPkg::ramAddrWidth)-1];

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write port
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (bus.ramWe) begin
            mem[bus.addr.mem.offset] <= bus.wrData;
        end
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read port
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Registered read, maps onto block RAM
    always_ff @(posedge clk) begin
        if (bus.ramRe) begin
            bus.ramRdData <= mem[bus.addr.mem.offset];
        end
    end

endmodule
`default_nettype wire

// File: hw/uartTransmitter.sv
`timescale 1ns/1ps
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Transmit-only UART, 8N1, LSB first
// Write to the data port starts a frame if idle
// Writes while busy are dropped, poll status first
// Status bit 0 is busy, other bits read 0
// busy leads txLine by one clk
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module uartTransmitter (
    input  logic clk,
    input  logic rst,
    cpuBusIf.uart bus,
    output logic txLine,
    output logic busy
);

    // Write aimed at the data port
    logic dataWrite;

    // Start request, one clk after the write strobe
    logic loadReq;
    logic [uartPkg::dataBits-1:0] loadData;

    // Frame shifter, bit 0 goes out next
    logic [uartPkg::frameBits-1:0] shiftReg;

    // Bit time and bit position
    logic [$clog2(uartPkg::clocksPerBit)-1:0] clkCnt;
    logic [$clog2(uartPkg::frameBits)-1:0] bitCnt;
    logic bitEnd;

    assign dataWrite = bus.ioWr && (bus.addr.io.port == cpuBusPkg::uartDataPort);
    assign bitEnd = busy && (int'(clkCnt) == uartPkg::clocksPerBit - 1);

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            loadReq <= 1'b0;
            busy <= 1'b0;
            clkCnt <= '0;
            bitCnt <= '0;
            txLine <= 1'b1;
        end else begin
            loadReq <= dataWrite;
            // Line idles high
            txLine <= busy ? shiftReg[0] : 1'b1;
            if (!busy) begin
                if (loadReq) begin
                    busy <= 1'b1;
                    clkCnt <= '0;
                    bitCnt <= '0;
                end
            end else if (bitEnd) begin
                clkCnt <= '0;
                // Last bit is the stop bit
                if (int'(bitCnt) == uartPkg::frameBits - 1) begin
                    busy <= 1'b0;
                end else begin
                    bitCnt <= bitCnt + 1'b1;
                end
            end else begin
                clkCnt <= clkCnt + 1'b1;
            end
        end
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Data path
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (dataWrite) begin
            loadData <= bus.wrData;
        end
        // Stop, data, start; refill with ones
        if (!busy && loadReq) begin
            shiftReg <= {1'b1, loadData, 1'b0};
        end else if (bitEnd) begin
            shiftReg <= {1'b1, shiftReg[uartPkg::frameBits-1:1]};
        end
    end

    // Status port read
    always_ff @(posedge clk) begin
        if (rst) begin
            bus.uartRdData <= '0;
        end else if (bus.ioRd && (bus.addr.io.port == cpuBusPkg::uartStatusPort)) begin
            bus.uartRdData <= {{(cpuBusPkg::dataWidth-1){1'b0}}, busy};
        end else begin
            bus.uartRdData <= '0;
        end
    end

    // Idle line is always mark
    txIdleHigh: assert property (
        @(posedge clk) disable iff (rst) !busy |-> txLine
    );

    // One frame keeps busy for 80 clk
    busyFrame: assert property (
        @(posedge clk) disable iff (rst)
        $rose(busy) |-> ##(uartPkg::clocksPerBit * uartPkg::frameBits) $fell(busy)
    );

endmodule
`default_nettype wire

// File: hw/hostTop.sv
`timescale 1ns/1ps
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host subsystem for a Z80-style CPU
// CPU lives outside and drives the active-low pins
// All logic on clk, cpuTick paces the CPU
// Peripherals reset from rst, cpuReset is for the CPU
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module hostTop (
    input  logic clk,
    input  logic rst,
    input  logic [cpuBusPkg::addrWidth-1:0] addr,
    input  logic [cpuBusPkg::dataWidth-1:0] wrData,
    output logic [cpuBusPkg::dataWidth-1:0] rdData,
    input  logic nMreq,
    input  logic nIorq,
    input  logic nRd,
    input  logic nWr,
    output logic uartTx,
    output logic cpuTick,
    output logic cpuReset
);

    // Decoded bus shared by decoder, RAM and UART
    cpuBusIf bus ();

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Clocking and reset
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    cpuTiming uTiming (
        .clk      (clk),
        .rst      (rst),
        .cpuTick  (cpuTick),
        .cpuReset (cpuReset)
    );

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus decode
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Flat address pins become the memory/IO union here
    busDecoder uDecoder (
        .clk    (clk),
        .rst    (rst),
        .addr   (cpuBusPkg::cpuAddrU'(addr)),
        .wrData (wrData),
        .nMreq  (nMreq),
        .nIorq  (nIorq),
        .nRd    (nRd),
        .nWr    (nWr),
        .rdData (rdData),
        .bus    (bus.decoder)
    );

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Peripherals
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    hostRam uRam (
        .clk (clk),
        .bus (bus.ram)
    );

    // Busy reaches the CPU through the status port only
    uartTransmitter uUart (
        .clk    (clk),
        .rst    (rst),
        .bus    (bus.uart),
        .txLine (uartTx),
        .busy   ()
    );

endmodule
`default_nettype wire

// File: verification/tbHost.sv
`timescale 1ns/1ps
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench acting as the Z80-style CPU
// Run from the project root, patterns come from
// verification/hostPatterns.txt
// Each bus operation holds the pins for 4 clk
// Read data is sampled 3 clk after the pins go low
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tbHost;

    // DUT pins
    logic clk;
    logic rst;
    logic [cpuBusPkg::addrWidth-1:0] addr;
    logic [cpuBusPkg::dataWidth-1:0] wrData;
    logic [cpuBusPkg::dataWidth-1:0] rdData;
    logic nMreq;
    logic nIorq;
    logic nRd;
    logic nWr;
    logic uartTx;
    logic cpuTick;
    logic cpuReset;

    // Frames seen on uartTx, oldest first
    logic [uartPkg::dataBits-1:0] frameQ [$];

    hostTop i_dut (
        .clk      (clk),
        .rst      (rst),
        .addr     (addr),
        .wrData   (wrData),
        .rdData   (rdData),
        .nMreq    (nMreq),
        .nIorq    (nIorq),
        .nRd      (nRd),
        .nWr      (nWr),
        .uartTx   (uartTx),
        .cpuTick  (cpuTick),
        .cpuReset (cpuReset)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Failure reporting and compares
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic failValue(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    // Plain-words stop for timeouts and file trouble
    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic checkData(input logic [cpuBusPkg::dataWidth-1:0] got,
                             input logic [cpuBusPkg::dataWidth-1:0] expected,
                             input string what);
        if (got !== expected) begin
            failValue($sformatf("%s: got %02h, expected %02h", what, got, expected));
        end
    endtask

    task automatic checkFrame(input logic [uartPkg::dataBits-1:0] got,
                              input logic [uartPkg::dataBits-1:0] expected);
        if (got !== expected) begin
            failValue($sformatf("UART frame: got %02h, expected %02h", got, expected));
        end
    endtask

    task automatic checkLevel(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            failValue($sformatf("%s: got %b, expected %b", what, got, expected));
        end
    endtask

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // CPU side of the bus
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // One memory or IO cycle, pins released on the 4th edge
    task automatic busCycle(input logic isIo, input logic isWrite,
                            input logic [cpuBusPkg::addrWidth-1:0] a,
                            input logic [cpuBusPkg::dataWidth-1:0] d,
                            output logic [cpuBusPkg::dataWidth-1:0] got);
        @(posedge clk);
        addr <= a;
        wrData <= d;
        nMreq <= isIo;
        nIorq <= !isIo;
        nRd <= isWrite;
        nWr <= !isWrite;
        repeat (3) @(posedge clk);
        // Decoder, RAM and mux registers have all settled
        @(negedge clk);
        got = rdData;
        @(posedge clk);
        nMreq <= 1'b1;
        nIorq <= 1'b1;
        nRd <= 1'b1;
        nWr <= 1'b1;
    endtask

    // Reset held 8 clk, then cpuReset release and tick spacing
    task automatic resetPhase();
        int cycles;
        repeat (7) @(posedge clk);
        @(negedge clk);
        checkLevel(uartTx, 1'b1, "uartTx in reset");
        checkLevel(cpuReset, 1'b1, "cpuReset in reset");
        checkLevel(cpuTick, 1'b0, "cpuTick in reset");
        @(posedge clk);
        rst <= 1'b0;
        cycles = 0;
        while (cpuReset !== 1'b0 && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (cpuReset !== 1'b0) begin
            abortRun("cpuReset did not fall within 20 cycles of reset release");
        end
        cycles = 0;
        while (cpuTick !== 1'b1 && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (cpuTick !== 1'b1) begin
            abortRun("no cpuTick pulse within 20 cycles");
        end
        // Next tick exactly 16 clk later, three times over
        for (int gapIdx = 0; gapIdx < 3; gapIdx++) begin
            for (int j = 1; j <= 16; j++) begin
                @(negedge clk);
                checkLevel(cpuTick, j == 16, "cpuTick spacing");
            end
        end
    endtask

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // UART line monitor
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Called in the first low cycle, samples each bit in its middle
    task automatic collectFrame();
        logic [uartPkg::dataBits-1:0] bits;
        repeat (uartPkg::clocksPerBit / 2) @(negedge clk);
        checkLevel(uartTx, 1'b0, "UART start bit");
        for (int i = 0; i < uartPkg::dataBits; i++) begin
            repeat (uartPkg::clocksPerBit) @(negedge clk);
            bits[i] = uartTx;
        end
        repeat (uartPkg::clocksPerBit) @(negedge clk);
        checkLevel(uartTx, 1'b1, "UART stop bit");
        // Past the end of the stop bit, transmitter idle again
        repeat (uartPkg::clocksPerBit / 2) @(negedge clk);
        frameQ.push_back(bits);
    endtask

    initial begin
        forever begin
            @(negedge clk);
            if (!rst && uartTx === 1'b0) begin
                collectFrame();
            end
        end
    end

    task automatic waitFrame(input logic [uartPkg::dataBits-1:0] expected);
        int cycles;
        cycles = 0;
        while (frameQ.size() == 0 && cycles < 300) begin
            @(posedge clk);
            cycles++;
        end
        if (frameQ.size() == 0) begin
            abortRun("no UART frame within 300 cycles");
        end else begin
            checkFrame(frameQ.pop_front(), expected);
        end
    endtask

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pattern replay
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic runPattern(input logic [15:0] op,
                              input logic [cpuBusPkg::addrWidth-1:0] a,
                              input logic [cpuBusPkg::dataWidth-1:0] d);
        logic [cpuBusPkg::dataWidth-1:0] got;
        int gap;
        case (op)
            "MW": busCycle(1'b0, 1'b1, a, d, got);
            "MR": begin
                busCycle(1'b0, 1'b0, a, 8'h00, got);
                checkData(got, d, $sformatf("memory read at %04h", a));
            end
            "IW": busCycle(1'b1, 1'b1, a, d, got);
            "IS": begin
                busCycle(1'b1, 1'b0, a, 8'h00, got);
                checkData(got, d, $sformatf("status read at %04h", a));
            end
            "TX": waitFrame(d);
            default: abortRun("unknown opcode in pattern file");
        endcase
        // Idle gap between CPU operations
        gap = int'($urandom % 6);
        repeat (gap) @(posedge clk);
    endtask

    initial begin
        int fd;
        int code;
        logic done;
        logic [15:0] op;
        logic [cpuBusPkg::addrWidth-1:0] addrVal;
        logic [cpuBusPkg::dataWidth-1:0] dataVal;
        logic [8*128-1:0] restOfLine;
        void'($urandom(16315));
        rst = 1'b1;
        addr = '0;
        wrData = '0;
        nMreq = 1'b1;
        nIorq = 1'b1;
        nRd = 1'b1;
        nWr = 1'b1;
        done = 1'b0;
        resetPhase();
        fd = $fopen("verification/hostPatterns.txt", "r");
        if (fd == 0) begin
            abortRun("cannot open verification/hostPatterns.txt");
        end
        while (!done) begin
            code = $fscanf(fd, "%s", op);
            if (code != 1) begin
                done = 1'b1;
            end else if (op == "//") begin
                // Comment line, drop the rest of it
                code = $fgets(restOfLine, fd);
            end else begin
                code = $fscanf(fd, "%h %h", addrVal, dataVal);
                if (code != 2) begin
                    abortRun("malformed line in pattern file");
                end else begin
                    runPattern(op, addrVal, dataVal);
                end
            end
        end
        $fclose(fd);
        // Two frame times with no traffic, a dropped byte must not show up
        repeat (2 * uartPkg::clocksPerBit * uartPkg::frameBits) @(posedge clk);
        checkLevel(frameQ.size() == 0, 1'b1, "no extra UART frame");
        $display("TEST OK");
        $finish;
    end

endmodule
`default_nettype wire

// File: verification/hostPatterns.txt
// op addr data (hex): MW/MR memory write/read, IW IO write, IS status read
// TX waits for a UART frame carrying data, addr unused
MW 0000 11
MW 0001 22
MW 03FF A5
MW 0155 5A
MR 0000 11
MR 0001 22
MR 03FF A5
MR 0155 5A
MW 0001 33
MR 0001 33
MR 0400 FF
MR 8001 FF
MW 0401 EE
MR 0001 33
MW FC00 77
MR 0000 11
IS 0100 00
IW 0000 55
IS 0100 01
IW 0000 AA
TX 0000 55
IS 0100 00
IW 0000 C3
TX 0000 C3
IS 0100 00

// File: hostTop.f
hw/cpuBusPkg.sv
hw/uartPkg.sv
hw/cpuBusIf.sv
hw/cpuTiming.sv
hw/busDecoder.sv
hw/hostRam.sv
hw/uartTransmitter.sv
hw/hostTop.sv
verification/tbHost.sv

// File: runSim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
# Exit status is 0 only when the pass line is found in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tbHost \
    -Mdir obj_dir \
    -f hostTop.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/VtbHost)
simStatus=$?
printf '%s\n' "$simOut"

if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if printf '%s\n' "$simOut" | grep -qx 'TEST OK'; then
    exit 0
fi

echo "pass line not found in simulation output"
exit 1
